// ==== verilog/riscv_core_settings.svh ====
// mini core build settings
`ifndef RISCV_CORE_SETTINGS_SVH
`define RISCV_CORE_SETTINGS_SVH

// datapath and address width
`define XLEN            32

// prefetch buffer
`define PREFETCH_DEPTH  4       // fifo entries
`define PREFETCH_CNT_W  3       // fill level, counts 0 to depth

// integer register file
`define NUM_REGS        32
`define REG_ADDR_W      5

// major opcodes accepted by execute
`define OPC_OP          7'b0110011  // register-register alu
`define OPC_OP_IMM      7'b0010011  // register-immediate alu

`define INSTR_STEP      4       // no compressed, so always one word

`endif

// ==== verilog/riscv_core_pkg.sv ====
// mini core shared types
`include "riscv_core_settings.svh"

package riscv_core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // fetch side
  ////////////////////////////////////////////////////////////////////////////

  // one word returned by instruction memory, tagged with its address
  typedef struct packed {
    logic [`XLEN-1:0] addr;   // address of the request
    logic [`XLEN-1:0] instr;  // raw instruction word
  } fetch_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // instruction formats
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]            imm12;   // sign extended in execute
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_type_t;

  // same 32 bits, seen as either format
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_word_u;

  ////////////////////////////////////////////////////////////////////////////
  // retire report
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       wdata;    // alu result, zero when illegal
    logic                   we;       // regfile actually written
    logic                   illegal;
    logic                   valid;    // one cycle per retired word
  } retire_t;

endpackage

// ==== verilog/riscv_fetch_unit.sv ====
// instruction fetch unit
`timescale 1ns/1ps
`include "riscv_core_settings.svh"

module riscv_fetch_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic [`XLEN-1:0]            boot_addr_i,     // sampled while in reset
  input  logic                        fetch_enable_i,

  // instruction memory, req/gnt/rvalid
  output logic                        instr_req_o,
  output logic [`XLEN-1:0]            instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [`XLEN-1:0]            instr_rdata_i,

  // towards the prefetch fifo
  input  logic [`PREFETCH_CNT_W-1:0]  fill_level_i,
  output logic                        push_o,
  output riscv_core_pkg::fetch_word_t push_word_o
);

  logic [`XLEN-1:0]           pc_q;          // next address to request
  logic [`XLEN-1:0]           req_addr_q;    // address of the granted request
  logic                       outstanding_q; // granted, rvalid not seen yet
  logic                       req_hold_q;    // req shown last cycle, no gnt

  logic [`PREFETCH_CNT_W-1:0] slots_used;
  logic                       room;
  logic                       slot_free;
  logic                       start_req;
  logic                       req_gnt;

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  // buffered words plus the one still in memory
  assign slots_used = fill_level_i + `PREFETCH_CNT_W'(outstanding_q);
  assign room       = slots_used < `PREFETCH_CNT_W'(`PREFETCH_DEPTH);

  // one in flight at most, but the returning one frees its slot this cycle
  assign slot_free  = ~outstanding_q | instr_rvalid_i;
  assign start_req  = fetch_enable_i & room & slot_free;

  // once raised, req stays up until gnt regardless of enable or fill
  assign instr_req_o  = req_hold_q | start_req;
  assign instr_addr_o = pc_q;   // pc only moves on gnt, so addr is stable
  assign req_gnt      = instr_req_o & instr_gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q          <= boot_addr_i;
      outstanding_q <= 1'b0;
      req_hold_q    <= 1'b0;
    end else begin
      if (req_gnt) begin
        pc_q <= pc_q + `XLEN'(`INSTR_STEP);  // straight line code only
      end

      // gnt of a new request may coincide with rvalid of the old one
      if (req_gnt) begin
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end

      req_hold_q <= instr_req_o & ~instr_gnt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_gnt) begin
      req_addr_q <= pc_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////////////////////

  // data pushed in the rvalid cycle itself
  assign push_o      = outstanding_q & instr_rvalid_i;
  assign push_word_o = '{addr: req_addr_q, instr: instr_rdata_i};

endmodule

// ==== verilog/riscv_prefetch_fifo.sv ====
// prefetch buffer
`timescale 1ns/1ps
`include "riscv_core_settings.svh"

module riscv_prefetch_fifo (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // write side, from fetch
  input  logic                        push_i,
  input  riscv_core_pkg::fetch_word_t push_word_i,

  // read side, first word falls through
  input  logic                        pop_i,
  output logic                        not_empty_o,
  output riscv_core_pkg::fetch_word_t head_o,

  output logic [`PREFETCH_CNT_W-1:0]  fill_level_o   // back to fetch for flow control
);

  localparam int PTR_W = $clog2(`PREFETCH_DEPTH);
  localparam logic [`PREFETCH_CNT_W-1:0] FULL_CNT = `PREFETCH_CNT_W'(`PREFETCH_DEPTH);

  riscv_core_pkg::fetch_word_t mem_q [`PREFETCH_DEPTH];

  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [`PREFETCH_CNT_W-1:0] count_q;
  logic                       do_push;
  logic                       do_pop;

  // wrap explicitly, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`PREFETCH_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push_i & (count_q != FULL_CNT);  // fetch never pushes when full
  assign do_pop  = pop_i & (count_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // pointers and fill level
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // both or neither, level unchanged
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_word_i;
    end
  end

  assign head_o       = mem_q[rd_ptr_q];
  assign not_empty_o  = (count_q != '0);
  assign fill_level_o = count_q;

endmodule

// ==== verilog/riscv_alu_exec.sv ====
// alu execute and retire
`timescale 1ns/1ps
`include "riscv_core_settings.svh"

module riscv_alu_exec (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // from the prefetch fifo
  input  logic                        not_empty_i,
  input  riscv_core_pkg::fetch_word_t head_i,
  output logic                        pop_o,

  output riscv_core_pkg::retire_t     retire_o     // registered
);

  // funct3 encodings shared by op and op-imm
  localparam logic [2:0] F3_ADD = 3'b000;   // add, sub, addi
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub

  localparam int SHAMT_W = $clog2(`XLEN);

  riscv_core_pkg::instr_word_u instr;
  riscv_core_pkg::retire_t     retire_q;

  logic [`XLEN-1:0] regs_q [`NUM_REGS];

  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;
  logic [`XLEN-1:0] imm_sext;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_result;
  logic             legal;
  logic             is_imm;
  logic             is_sub;
  logic             wr_en;

  // one instruction per cycle, no stall source downstream
  assign pop_o = not_empty_i;
  assign instr = head_i.instr;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    legal  = 1'b0;
    is_imm = 1'b0;
    is_sub = 1'b0;
    case (instr.r.opcode)
      `OPC_OP: begin
        if (instr.r.funct7 == F7_BASE) begin
          case (instr.r.funct3)
            F3_ADD, F3_SLL, F3_SLT, F3_XOR, F3_SRL, F3_OR, F3_AND: legal = 1'b1;
            default: legal = 1'b0;   // sltu not in this core
          endcase
        end else if ((instr.r.funct7 == F7_ALT) && (instr.r.funct3 == F3_ADD)) begin
          legal  = 1'b1;
          is_sub = 1'b1;
        end
      end
      `OPC_OP_IMM: begin
        is_imm = 1'b1;
        case (instr.i.funct3)
          F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND: legal = 1'b1;
          default: legal = 1'b0;     // no immediate shifts, no sltiu
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // operands
  ////////////////////////////////////////////////////////////////////////////

  assign rs1_val  = (instr.r.rs1 == '0) ? '0 : regs_q[instr.r.rs1];  // x0 hardwired
  assign rs2_val  = (instr.r.rs2 == '0) ? '0 : regs_q[instr.r.rs2];
  assign imm_sext = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
  assign op_b     = is_imm ? imm_sext : rs2_val;

  // alu
  always_comb begin
    case (instr.r.funct3)
      F3_ADD:  alu_result = is_sub ? (rs1_val - op_b) : (rs1_val + op_b);
      F3_SLL:  alu_result = rs1_val << op_b[SHAMT_W-1:0];
      F3_SLT:  alu_result = {{(`XLEN-1){1'b0}}, ($signed(rs1_val) < $signed(op_b))};
      F3_XOR:  alu_result = rs1_val ^ op_b;
      F3_SRL:  alu_result = rs1_val >> op_b[SHAMT_W-1:0];  // logical only
      F3_OR:   alu_result = rs1_val | op_b;
      F3_AND:  alu_result = rs1_val & op_b;
      default: alu_result = '0;
    endcase
  end

  assign wr_en = legal & (instr.r.rd != '0);   // x0 writes reported, not done

  ////////////////////////////////////////////////////////////////////////////
  // register file and retire
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (pop_o && wr_en) begin
      regs_q[instr.r.rd] <= alu_result;  // visible to the next pop
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retire_q <= '0;
    end else begin
      retire_q.valid <= pop_o;           // one clock after the pop
      if (pop_o) begin
        retire_q.pc      <= head_i.addr;
        retire_q.rd      <= instr.r.rd;
        retire_q.wdata   <= legal ? alu_result : '0;
        retire_q.we      <= wr_en;
        retire_q.illegal <= ~legal;
      end
    end
  end

  assign retire_o = retire_q;

endmodule

// ==== verilog/riscv_mini_core.sv ====
// mini core top level
`timescale 1ns/1ps
`include "riscv_core_settings.svh"

module riscv_mini_core (
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  logic [`XLEN-1:0]        boot_addr_i,
  input  logic                    fetch_enable_i,

  // instruction memory interface
  output logic                    instr_req_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  output logic [`XLEN-1:0]        instr_addr_o,
  input  logic [`XLEN-1:0]        instr_rdata_i,

  output riscv_core_pkg::retire_t retire_o
);

  // fetch -> fifo
  logic                        push;
  riscv_core_pkg::fetch_word_t push_word;
  logic [`PREFETCH_CNT_W-1:0]  fill_level;   // flow control back to fetch

  // fifo -> execute
  logic                        pop;
  logic                        not_empty;
  riscv_core_pkg::fetch_word_t head;

  ////////////////////////////////////////////////////////////////////////////
  // fetch, buffer, execute
  ////////////////////////////////////////////////////////////////////////////

  riscv_fetch_unit fetch_unit_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fill_level_i   ( fill_level     ),
    .push_o         ( push           ),
    .push_word_o    ( push_word      )
  );

  riscv_prefetch_fifo prefetch_fifo_i (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .push_i       ( push       ),
    .push_word_i  ( push_word  ),
    .pop_i        ( pop        ),
    .not_empty_o  ( not_empty  ),
    .head_o       ( head       ),
    .fill_level_o ( fill_level )
  );

  riscv_alu_exec alu_exec_i (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .not_empty_i ( not_empty ),
    .head_i      ( head      ),
    .pop_o       ( pop       ),
    .retire_o    ( retire_o  )   // registered inside execute
  );

endmodule

// ==== sim/riscv_mini_core_sva.sv ====
// mini core interface assertions
`timescale 1ns/1ps
`include "riscv_core_settings.svh"

module riscv_mini_core_sva (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    instr_req_o,
  input logic                    instr_gnt_i,
  input logic                    instr_rvalid_i,
  input logic [`XLEN-1:0]        instr_addr_o,
  input riscv_core_pkg::retire_t retire_o
);

  logic granted_q;   // granted request still waiting for rvalid

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      granted_q <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      granted_q <= 1'b1;             // new grant wins over a same cycle rvalid
    end else if (instr_rvalid_i) begin
      granted_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // instruction memory handshake
  ////////////////////////////////////////////////////////////////////////////

  req_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request or address changed before grant");

  rvalid_granted_a: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_rvalid_i |-> granted_q)
    else $error("rvalid without an outstanding grant");

  // retire report
  we_rd_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
    retire_o.valid && retire_o.we |-> retire_o.rd != '0)
    else $error("register write reported for x0");

  we_illegal_a: assert property (@(posedge clk_i) disable iff (reset_i)
    retire_o.valid |-> !(retire_o.we && retire_o.illegal))
    else $error("register write reported for an illegal instruction");

endmodule

// ==== sim/tb_riscv_mini_core.sv ====
// mini core testbench
`timescale 1ns/1ps
`include "riscv_core_settings.svh"

module tb_riscv_mini_core;

  localparam int unsigned      SEED         = 32'h479e6f8f;
  localparam int               CLK_PERIOD   = 100;            // ns
  localparam int               RESET_CYCLES = 16;
  localparam int               IDLE_CYCLES  = 6;              // enable kept low after reset
  localparam int               DRAIN_CYCLES = 20;
  localparam int               PROG_LEN     = 200;            // words in the program
  localparam int               MAX_GNT_WAIT = 3;
  localparam int               MAX_RV_WAIT  = 3;
  localparam int               MAX_EN_HOLD  = 4;
  localparam logic [`XLEN-1:0] BOOT_ADDR    = 32'h1c00_0080;

  // enable gap, grant wait, rvalid wait, then fifo and execute
  localparam int WORST_CYCLES   = (MAX_EN_HOLD + 1) + (MAX_GNT_WAIT + 1) + (MAX_RV_WAIT + 1) + 2;
  localparam int TIMEOUT_CYCLES = PROG_LEN * WORST_CYCLES * 2
                                + RESET_CYCLES + IDLE_CYCLES + DRAIN_CYCLES;

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  logic [`XLEN-1:0]        boot_addr_i;
  logic                    fetch_enable_i;
  logic                    instr_req_o;
  logic                    instr_gnt_i;
  logic                    instr_rvalid_i;
  logic [`XLEN-1:0]        instr_addr_o;
  logic [`XLEN-1:0]        instr_rdata_i;
  riscv_core_pkg::retire_t retire_o;

  logic [`XLEN-1:0] prog [PROG_LEN];             // program image from boot_addr up
  logic [`XLEN-1:0] shadow_regs [`NUM_REGS];     // reference register file
  logic [`XLEN-1:0] exp_addr;                    // next address fetch must ask for

  int grant_cnt   = 0;
  int retired_cnt = 0;
  int pend_idx    = 0;     // program index of the word in memory
  int gnt_wait    = 0;
  int rv_wait     = 0;
  int en_hold     = 0;
  bit pend        = 1'b0;  // granted, response not yet given
  bit run_active  = 1'b0;
  bit enable_seen = 1'b0;
  bit pass_shown  = 1'b0;
  bit fail_shown  = 1'b0;

  riscv_mini_core i_riscv_mini_core (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .retire_o       ( retire_o       )
  );

  bind riscv_mini_core riscv_mini_core_sva mini_core_sva_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .retire_o       ( retire_o       )
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // error reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    fail_shown = 1'b1;
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] exp);
    stop_on_error($sformatf("mismatch at %0d ns: %s got 0x%08h expected 0x%08h",
                            $time, name, got, exp));
  endtask

  task automatic check_addr(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
    if (got !== exp) report_mismatch("instr_addr_o", got, exp);
  endtask

  task automatic check_retire(input riscv_core_pkg::retire_t got,
                              input riscv_core_pkg::retire_t exp);
    if (got.pc !== exp.pc)           report_mismatch("retire_o.pc", got.pc, exp.pc);
    if (got.rd !== exp.rd)           report_mismatch("retire_o.rd", got.rd, exp.rd);
    if (got.illegal !== exp.illegal) report_mismatch("retire_o.illegal", got.illegal, exp.illegal);
    if (got.we !== exp.we)           report_mismatch("retire_o.we", got.we, exp.we);
    if (got.wdata !== exp.wdata)     report_mismatch("retire_o.wdata", got.wdata, exp.wdata);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and program generation
  ////////////////////////////////////////////////////////////////////////////

  // expected retire report, reads the shadow register file
  function automatic riscv_core_pkg::retire_t ref_retire(input logic [`XLEN-1:0] pc,
                                                          input logic [`XLEN-1:0] word);
    riscv_core_pkg::instr_word_u w;
    riscv_core_pkg::retire_t     r;
    logic [`XLEN-1:0]            a;
    logic [`XLEN-1:0]            b;
    logic [`XLEN-1:0]            imm;
    logic                        ok;
    w   = word;
    r   = '0;
    ok  = 1'b1;
    a   = (w.r.rs1 == '0) ? '0 : shadow_regs[w.r.rs1];   // x0 reads zero
    b   = (w.r.rs2 == '0) ? '0 : shadow_regs[w.r.rs2];
    imm = {{(`XLEN-12){w.i.imm12[11]}}, w.i.imm12};
    if (w.r.opcode == `OPC_OP && w.r.funct7 == 7'b0100000 && w.r.funct3 == 3'b000) begin
      r.wdata = a - b;                                   // sub
    end else if (w.r.opcode == `OPC_OP && w.r.funct7 == 7'b0000000) begin
      case (w.r.funct3)
        3'b000:  r.wdata = a + b;
        3'b001:  r.wdata = a << b[4:0];
        3'b010:  r.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  r.wdata = a ^ b;
        3'b101:  r.wdata = a >> b[4:0];
        3'b110:  r.wdata = a | b;
        3'b111:  r.wdata = a & b;
        default: ok = 1'b0;                              // sltu
      endcase
    end else if (w.i.opcode == `OPC_OP_IMM) begin
      case (w.i.funct3)
        3'b000:  r.wdata = a + imm;
        3'b010:  r.wdata = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
        3'b100:  r.wdata = a ^ imm;
        3'b110:  r.wdata = a | imm;
        3'b111:  r.wdata = a & imm;
        default: ok = 1'b0;                              // shifts, sltiu
      endcase
    end else begin
      ok = 1'b0;
    end
    r.pc      = pc;
    r.rd      = w.r.rd;
    r.valid   = 1'b1;
    r.illegal = ~ok;
    r.we      = ok && (w.r.rd != '0);
    if (!ok) r.wdata = '0;
    return r;
  endfunction

  function automatic logic [`XLEN-1:0] gen_legal_word();
    riscv_core_pkg::instr_word_u w;
    int unsigned                 pick;
    pick = $urandom % 16;
    if (pick >= 13) pick = 8;            // extra addi to fill registers
    w.r.rd  = 5'($urandom % 8);          // few registers, many dependencies
    w.r.rs1 = 5'($urandom % 8);
    if (pick < 8) begin
      w.r.opcode = `OPC_OP;
      w.r.rs2    = 5'($urandom % 8);
      w.r.funct7 = (pick == 1) ? 7'b0100000 : 7'b0000000;
      case (pick)
        0, 1:    w.r.funct3 = 3'b000;    // add, sub
        2:       w.r.funct3 = 3'b001;
        3:       w.r.funct3 = 3'b010;
        4:       w.r.funct3 = 3'b100;
        5:       w.r.funct3 = 3'b101;
        6:       w.r.funct3 = 3'b110;
        default: w.r.funct3 = 3'b111;
      endcase
    end else begin
      w.i.opcode = `OPC_OP_IMM;
      w.i.imm12  = 12'($urandom);
      case (pick)
        8:       w.i.funct3 = 3'b000;
        9:       w.i.funct3 = 3'b010;
        10:      w.i.funct3 = 3'b100;
        11:      w.i.funct3 = 3'b110;
        default: w.i.funct3 = 3'b111;
      endcase
    end
    return w;
  endfunction

  function automatic logic [`XLEN-1:0] gen_illegal_word();
    logic [`XLEN-1:0] w;
    w = $urandom;
    case ($urandom % 3)
      0: begin                           // opcode outside the alu
        case ($urandom % 3)
          0:       w[6:0] = 7'b0000011;
          1:       w[6:0] = 7'b0100011;
          default: w[6:0] = 7'b1100011;
        endcase
      end
      1: begin                           // mul encoding
        w[31:25] = 7'b0000001;
        w[6:0]   = `OPC_OP;
      end
      default: begin                     // slli not supported
        w[14:12] = 3'b001;
        w[6:0]   = `OPC_OP_IMM;
      end
    endcase
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory model, fetch bookkeeping, retire compare
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (run_active) begin
      if (gnt_wait != 0) begin
        instr_gnt_i = 1'b0;
        gnt_wait--;
      end else begin
        instr_gnt_i = 1'b1;
      end
      if (pend && rv_wait == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = prog[pend_idx];
      end else begin
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        if (pend) rv_wait--;
      end
      if (grant_cnt >= PROG_LEN) begin
        fetch_enable_i = 1'b0;           // whole program requested
      end else if (en_hold != 0) begin
        en_hold--;
      end else begin
        fetch_enable_i = ($urandom % 4) != 0;
        en_hold        = $urandom % (MAX_EN_HOLD + 1);
      end
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (!enable_seen && !fetch_enable_i) begin
        if (instr_req_o) stop_on_error("instruction request raised before fetch enable");
        if (retire_o.valid) stop_on_error("retire reported before fetch enable");
      end
      if (fetch_enable_i) enable_seen = 1'b1;
      if (instr_rvalid_i) pend = 1'b0;   // response consumed this cycle
      if (instr_req_o && instr_gnt_i) begin
        if (pend) stop_on_error("second request granted while one is outstanding");
        if (grant_cnt >= PROG_LEN) stop_on_error("request granted beyond the end of the program");
        check_addr(instr_addr_o, exp_addr);
        exp_addr = exp_addr + `XLEN'(`INSTR_STEP);
        pend     = 1'b1;
        pend_idx = grant_cnt;
        rv_wait  = $urandom % (MAX_RV_WAIT + 1);
        gnt_wait = $urandom % (MAX_GNT_WAIT + 1);
        grant_cnt++;
      end
    end
  end

  always @(posedge clk_i) begin : compare_retire
    riscv_core_pkg::retire_t exp_ret;
    if (!reset_i && retire_o.valid) begin
      if (retired_cnt >= PROG_LEN) stop_on_error("more instructions retired than fetched");
      exp_ret = ref_retire(BOOT_ADDR + `XLEN'(retired_cnt * `INSTR_STEP), prog[retired_cnt]);
      check_retire(retire_o, exp_ret);
      if (exp_ret.we) shadow_regs[exp_ret.rd] = exp_ret.wdata;
      retired_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    reset_i        = 1'b1;
    boot_addr_i    = BOOT_ADDR;         // taken by the pc during reset
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    exp_addr       = BOOT_ADDR;
    for (int i = 0; i < `NUM_REGS; i++) begin
      shadow_regs[i] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      prog[i] = (($urandom % 12) == 0) ? gen_illegal_word() : gen_legal_word();
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (IDLE_CYCLES) @(negedge clk_i);   // quiet window, enable still low
    @(posedge clk_i);
    run_active = 1'b1;                       // memory model starts on the next falling edge
    while (retired_cnt < PROG_LEN) @(negedge clk_i);
    repeat (DRAIN_CYCLES) @(negedge clk_i);  // nothing more may retire
    if (grant_cnt != PROG_LEN) begin
      stop_on_error("number of granted requests is wrong");
    end else begin
      pass_shown = 1'b1;
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    stop_on_error($sformatf("timeout after %0d cycles, %0d of %0d instructions retired",
                            TIMEOUT_CYCLES, retired_cnt, PROG_LEN));
  end

  // run stopped by an assertion or the simulator
  final begin
    if (!pass_shown && !fail_shown) begin
      $display("run ended without reaching the end of the test");
      $display("TEST RESULT: FAIL");
    end
  end

endmodule

// ==== riscv_mini_core.f ====
+incdir+verilog
verilog/riscv_core_pkg.sv
verilog/riscv_fetch_unit.sv
verilog/riscv_prefetch_fifo.sv
verilog/riscv_alu_exec.sv
verilog/riscv_mini_core.sv
sim/riscv_mini_core_sva.sv
sim/tb_riscv_mini_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mini core testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_riscv_mini_core
OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" \
  -f riscv_mini_core.f \
  --Mdir "$OBJ_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "error: verilator compile failed"
  exit 1
fi

# output kept in a variable, no log file
sim_out=$("./$OBJ_DIR/V$TOP" 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "error: simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^TEST RESULT: PASS$'; then
  exit 0
fi
echo "error: pass message not found in simulation output"
exit 1
